// ==== Makefile ====
# Verilator build and run for the rvCore testbench

VERILATOR ?= verilator
TOP       ?= rvCoreTb
BUILD_DIR ?= build
LOG       ?= sim.log
FILELIST  ?= rvCore.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" $(LOG); then \
	  echo "simulation reported an error, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/instDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module instDecoder (
  input  logic                clk,
  input  logic                rst,
  input  logic                instValid,
  input  rvCorePkg::instWord  instIn,
  output logic                instCredit,
  output logic                decValid,
  output rvCorePkg::decodedOp decOp,
  input  logic                execReady
);
  import rvCorePkg::*;

  instWord                   queue [InQueueDepth];
  logic [InQueuePtrBits-1:0] wrPtr;
  logic [InQueuePtrBits-1:0] rdPtr;
  logic [InQueuePtrBits:0]   count;
  logic                      queueEmpty;
  logic                      loadEn;
  logic                      takeInst;
  logic                      pushEn;
  logic                      popEn;
  instWord                   word;
  logic [6:0]                opcode;
  logic [2:0]                funct3;
  logic [6:0]                funct7;
  xword                      immI;
  xword                      immB;
  xword                      immU;
  xword                      immJ;
  logic                      immLegal;
  logic                      imm32Legal;
  logic                      regLegal;
  decodedOp                  dec;

  function automatic aluOpE mapAluOp(input logic [2:0] f3, input logic alt);
    case (f3)
      F3Add:   mapAluOp = alt ? AluSub : AluAdd;
      F3Sll:   mapAluOp = AluSll;
      F3Slt:   mapAluOp = AluSlt;
      F3Sltu:  mapAluOp = AluSltu;
      F3Xor:   mapAluOp = AluXor;
      F3Srl:   mapAluOp = alt ? AluSra : AluSrl;
      F3Or:    mapAluOp = AluOr;
      default: mapAluOp = AluAnd;
    endcase
  endfunction

  // an empty queue lets the incoming word fall straight into decode
  assign queueEmpty = (count == '0);
  assign loadEn     = !decValid || execReady;
  assign takeInst   = loadEn && (!queueEmpty || instValid);
  assign pushEn     = instValid && !(queueEmpty && takeInst);
  assign popEn      = takeInst && !queueEmpty;
  assign word       = queueEmpty ? instIn : queue[rdPtr];

  assign opcode = word[6:0];
  assign funct3 = word[14:12];
  assign funct7 = word[31:25];

  assign immI = {{52{word[31]}}, word[31:20]};
  assign immB = {{52{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
  assign immU = {{32{word[31]}}, word[31:12], 12'h000};
  assign immJ = {{44{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};

  // shift immediates carry shamt in the low bits of funct7
  assign immLegal = (funct3 == F3Sll) ? (funct7[6:1] == F6Base) :
                    (funct3 == F3Srl) ? (funct7[6:1] == F6Base || funct7[6:1] == F6Alt) :
                    1'b1;
  assign imm32Legal = (funct3 == F3Add) ||
                      (funct3 == F3Sll && funct7 == F7Base) ||
                      (funct3 == F3Srl && (funct7 == F7Base || funct7 == F7Alt));
  assign regLegal = (funct7 == F7Base) ||
                    (funct7 == F7Alt && (funct3 == F3Add || funct3 == F3Srl));

  always_comb begin
    dec         = '0;
    dec.opClass = ClsNop;
    dec.aluOp   = AluAdd;
    dec.funct3  = funct3;
    dec.rs1     = word[19:15];
    dec.rs2     = word[24:20];
    dec.rd      = word[11:7];
    dec.imm     = immI;
    case (opcode)
      OpLui: begin
        dec.opClass = ClsLui;
        dec.imm     = immU;
        dec.rdWrite = 1'b1;
      end
      OpAuipc: begin
        dec.opClass = ClsAuipc;
        dec.imm     = immU;
        dec.rdWrite = 1'b1;
      end
      OpJal: begin
        dec.opClass = ClsJal;
        dec.imm     = immJ;
        dec.rdWrite = 1'b1;
      end
      OpJalr: begin
        if (funct3 == F3Jalr) begin
          dec.opClass = ClsJalr;
          dec.useImm  = 1'b1;
          dec.rdWrite = 1'b1;
        end
      end
      OpBranch: begin
        // compare goes through the subtractor
        if (funct3 inside {F3Beq, F3Bne, F3Blt, F3Bge, F3Bltu, F3Bgeu}) begin
          dec.opClass = ClsBranch;
          dec.aluOp   = AluSub;
          dec.imm     = immB;
        end
      end
      OpImm: begin
        if (immLegal) begin
          dec.opClass = ClsAlu;
          dec.aluOp   = mapAluOp(funct3, funct3 == F3Srl && funct7[5]);
          dec.useImm  = 1'b1;
          dec.rdWrite = 1'b1;
        end
      end
      OpImm32: begin
        if (imm32Legal) begin
          dec.opClass = ClsAlu;
          dec.aluOp   = mapAluOp(funct3, funct3 == F3Srl && funct7[5]);
          dec.useImm  = 1'b1;
          dec.word32  = 1'b1;
          dec.rdWrite = 1'b1;
        end
      end
      OpReg: begin
        if (regLegal) begin
          dec.opClass = ClsAlu;
          dec.aluOp   = mapAluOp(funct3, funct7[5]);
          dec.rdWrite = 1'b1;
        end
      end
      OpReg32: begin
        if (regLegal && funct3 inside {F3Add, F3Sll, F3Srl}) begin
          dec.opClass = ClsAlu;
          dec.aluOp   = mapAluOp(funct3, funct7[5]);
          dec.word32  = 1'b1;
          dec.rdWrite = 1'b1;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (pushEn) begin
      queue[wrPtr] <= instIn;
    end
    if (takeInst) begin
      decOp <= dec;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr      <= '0;
      rdPtr      <= '0;
      count      <= '0;
      instCredit <= 1'b0;
      decValid   <= 1'b0;
    end else begin
      if (pushEn) begin
        wrPtr <= wrPtr + InQueuePtrBits'(1);
      end
      if (popEn) begin
        rdPtr <= rdPtr + InQueuePtrBits'(1);
      end
      count <= count + {{InQueuePtrBits{1'b0}}, pushEn} - {{InQueuePtrBits{1'b0}}, popEn};
      // one credit back per word that reaches decode
      instCredit <= takeInst;
      if (loadEn) begin
        decValid <= takeInst;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/intExecute.sv ====
`timescale 1ns/10ps
`default_nettype none

module intExecute (
  input  logic                clk,
  input  logic                rst,
  input  logic                decValid,
  input  rvCorePkg::decodedOp decOp,
  output logic                execReady,
  output rvCorePkg::regIdx    rs1,
  output rvCorePkg::regIdx    rs2,
  input  rvCorePkg::xword     rs1Data,
  input  rvCorePkg::xword     rs2Data,
  input  logic                fwdValid,
  input  rvCorePkg::retireRec fwdRec,
  output logic                exValid,
  output rvCorePkg::retireRec exRec,
  input  logic                retireReady
);
  import rvCorePkg::*;

  xword          pc;
  xword          opA;
  xword          opB;
  xword          aluB;
  xword          aluRaw;
  xword          aluRes;
  xword          srlSrc;
  xword          sraSrc;
  xword          pcPlus4;
  xword          pcPlusImm;
  logic [XLen:0] diff;
  logic [5:0]    shamt;
  logic          overflow;
  logic          lessSigned;
  logic          lessUnsigned;
  logic          taken;
  logic          exLoad;
  retireRec      rec;

  function automatic logic hits(input logic valid, input retireRec r, input regIdx idx);
    return valid && r.rdWrite && (r.rd != '0) && (r.rd == idx);
  endfunction

  assign rs1       = decOp.rs1;
  assign rs2       = decOp.rs2;
  assign execReady = !exValid || retireReady;
  assign exLoad    = decValid && execReady;

  // newest producer first: own register, then the retire record
  assign opA = hits(exValid, exRec, decOp.rs1)   ? exRec.rdValue  :
               hits(fwdValid, fwdRec, decOp.rs1) ? fwdRec.rdValue :
               rs1Data;
  assign opB = hits(exValid, exRec, decOp.rs2)   ? exRec.rdValue  :
               hits(fwdValid, fwdRec, decOp.rs2) ? fwdRec.rdValue :
               rs2Data;

  assign aluB  = decOp.useImm ? decOp.imm : opB;
  assign shamt = decOp.word32 ? {1'b0, aluB[4:0]} : aluB[5:0];

  assign diff         = {1'b0, opA} + {1'b0, ~aluB} + 1'b1;
  assign overflow     = (opA[XLen-1] != aluB[XLen-1]) && (diff[XLen-1] != opA[XLen-1]);
  assign lessSigned   = diff[XLen-1] ^ overflow;
  assign lessUnsigned = !diff[XLen];

  assign srlSrc = decOp.word32 ? {32'h0, opA[31:0]} : opA;
  assign sraSrc = decOp.word32 ? {{32{opA[31]}}, opA[31:0]} : opA;

  always_comb begin
    case (decOp.aluOp)
      AluAdd:  aluRaw = opA + aluB;
      AluSub:  aluRaw = diff[XLen-1:0];
      AluSll:  aluRaw = opA << shamt;
      AluSlt:  aluRaw = {{(XLen-1){1'b0}}, lessSigned};
      AluSltu: aluRaw = {{(XLen-1){1'b0}}, lessUnsigned};
      AluXor:  aluRaw = opA ^ aluB;
      AluSrl:  aluRaw = srlSrc >> shamt;
      AluSra:  aluRaw = $signed(sraSrc) >>> shamt;
      AluOr:   aluRaw = opA | aluB;
      AluAnd:  aluRaw = opA & aluB;
      default: aluRaw = '0;
    endcase
  end

  assign aluRes = decOp.word32 ? {{32{aluRaw[31]}}, aluRaw[31:0]} : aluRaw;

  always_comb begin
    case (decOp.funct3)
      F3Beq:   taken = (opA == opB);
      F3Bne:   taken = (opA != opB);
      F3Blt:   taken = lessSigned;
      F3Bge:   taken = !lessSigned;
      F3Bltu:  taken = lessUnsigned;
      F3Bgeu:  taken = !lessUnsigned;
      default: taken = 1'b0;
    endcase
  end

  assign pcPlus4   = pc + 64'd4;
  assign pcPlusImm = pc + decOp.imm;

  always_comb begin
    rec.pc      = pc;
    rec.nextPc  = pcPlus4;
    rec.rd      = decOp.rd;
    rec.rdWrite = decOp.rdWrite;
    // branches and nops carry a zero result
    rec.rdValue = '0;
    case (decOp.opClass)
      ClsLui: rec.rdValue = decOp.imm;
      ClsAuipc: rec.rdValue = pcPlusImm;
      ClsJal: begin
        rec.rdValue = pcPlus4;
        rec.nextPc  = pcPlusImm;
      end
      ClsJalr: begin
        rec.rdValue = pcPlus4;
        rec.nextPc  = {aluRes[XLen-1:1], 1'b0};
      end
      ClsBranch: rec.nextPc = taken ? pcPlusImm : pcPlus4;
      ClsAlu: rec.rdValue = aluRes;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (exLoad) begin
      exRec <= rec;
    end
  end

  // pc follows each record as it is handed to retire
  always_ff @(posedge clk) begin
    if (rst) begin
      exValid <= 1'b0;
      pc      <= ResetPc;
    end else begin
      if (execReady) begin
        exValid <= decValid;
      end
      if (exLoad) begin
        pc <= rec.nextPc;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regFile (
  input  logic             clk,
  input  rvCorePkg::regIdx rs1,
  input  rvCorePkg::regIdx rs2,
  output rvCorePkg::xword  rs1Data,
  output rvCorePkg::xword  rs2Data,
  input  logic             wrEn,
  input  rvCorePkg::regIdx wrAddr,
  input  rvCorePkg::xword  wrData
);
  import rvCorePkg::*;

  // x0 has no storage
  xword regs [1:31];

  assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (wrEn && wrAddr != '0) begin
      regs[wrAddr] <= wrData;
    end
  end

endmodule

`default_nettype wire

// ==== design/retireStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module retireStage (
  input  logic                clk,
  input  logic                rst,
  input  logic                exValid,
  input  rvCorePkg::retireRec exRec,
  output logic                retireReady,
  input  logic                retireCredit,
  output logic                retireValid,
  output rvCorePkg::retireRec retireOut,
  output logic                fwdValid,
  output rvCorePkg::retireRec fwdRec,
  output logic                wrEn,
  output rvCorePkg::regIdx    wrAddr,
  output rvCorePkg::xword     wrData
);
  import rvCorePkg::*;

  logic                  recValid;
  retireRec              rec;
  logic [CreditBits-1:0] creditCnt;
  logic                  fire;

  assign fire        = recValid && (creditCnt != '0);
  assign retireReady = !recValid || fire;

  assign retireValid = fire;
  assign retireOut   = rec;
  assign fwdValid    = recValid;
  assign fwdRec      = rec;

  // writeback happens as the record leaves
  assign wrEn   = fire && rec.rdWrite;
  assign wrAddr = rec.rd;
  assign wrData = rec.rdValue;

  always_ff @(posedge clk) begin
    if (exValid && retireReady) begin
      rec <= exRec;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      recValid  <= 1'b0;
      creditCnt <= '0;
    end else begin
      if (retireReady) begin
        recValid <= exValid;
      end
      case ({retireCredit, fire})
        2'b10:   creditCnt <= creditCnt + CreditBits'(1);
        2'b01:   creditCnt <= creditCnt - CreditBits'(1);
        default: creditCnt <= creditCnt;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/rvCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvCore (
  input  logic                clk,
  input  logic                rst,
  input  logic                instValid,
  input  rvCorePkg::instWord  instIn,
  output logic                instCredit,
  output logic                retireValid,
  output rvCorePkg::retireRec retireOut,
  input  logic                retireCredit
);
  import rvCorePkg::*;

  logic     decValid;
  decodedOp decOp;
  logic     execReady;
  regIdx    rs1;
  regIdx    rs2;
  xword     rs1Data;
  xword     rs2Data;
  logic     exValid;
  retireRec exRec;
  logic     retireReady;
  logic     fwdValid;
  retireRec fwdRec;
  logic     wrEn;
  regIdx    wrAddr;
  xword     wrData;

  instDecoder uDecoder (
    .clk        (clk),
    .rst        (rst),
    .instValid  (instValid),
    .instIn     (instIn),
    .instCredit (instCredit),
    .decValid   (decValid),
    .decOp      (decOp),
    .execReady  (execReady)
  );

  intExecute uExecute (
    .clk         (clk),
    .rst         (rst),
    .decValid    (decValid),
    .decOp       (decOp),
    .execReady   (execReady),
    .rs1         (rs1),
    .rs2         (rs2),
    .rs1Data     (rs1Data),
    .rs2Data     (rs2Data),
    .fwdValid    (fwdValid),
    .fwdRec      (fwdRec),
    .exValid     (exValid),
    .exRec       (exRec),
    .retireReady (retireReady)
  );

  regFile uRegFile (
    .clk     (clk),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1Data (rs1Data),
    .rs2Data (rs2Data),
    .wrEn    (wrEn),
    .wrAddr  (wrAddr),
    .wrData  (wrData)
  );

  retireStage uRetire (
    .clk          (clk),
    .rst          (rst),
    .exValid      (exValid),
    .exRec        (exRec),
    .retireReady  (retireReady),
    .retireCredit (retireCredit),
    .retireValid  (retireValid),
    .retireOut    (retireOut),
    .fwdValid     (fwdValid),
    .fwdRec       (fwdRec),
    .wrEn         (wrEn),
    .wrAddr       (wrAddr),
    .wrData       (wrData)
  );

endmodule

`default_nettype wire

// ==== design/rvCorePkg.sv ====
`default_nettype none

package rvCorePkg;

  localparam int XLen           = 64;
  localparam int RegAddrBits    = 5;
  localparam int InQueueDepth   = 4;
  localparam int InQueuePtrBits = $clog2(InQueueDepth);
  localparam int CreditBits     = 4;

  typedef logic [31:0]            instWord;
  typedef logic [XLen-1:0]        xword;
  typedef logic [RegAddrBits-1:0] regIdx;

  localparam xword ResetPc = 64'h0000_0000_8000_0000;

  // major opcodes
  localparam logic [6:0] OpLui    = 7'b0110111;
  localparam logic [6:0] OpAuipc  = 7'b0010111;
  localparam logic [6:0] OpJal    = 7'b1101111;
  localparam logic [6:0] OpJalr   = 7'b1100111;
  localparam logic [6:0] OpBranch = 7'b1100011;
  localparam logic [6:0] OpImm    = 7'b0010011;
  localparam logic [6:0] OpImm32  = 7'b0011011;
  localparam logic [6:0] OpReg    = 7'b0110011;
  localparam logic [6:0] OpReg32  = 7'b0111011;

  // arithmetic funct3
  localparam logic [2:0] F3Add  = 3'b000;
  localparam logic [2:0] F3Sll  = 3'b001;
  localparam logic [2:0] F3Slt  = 3'b010;
  localparam logic [2:0] F3Sltu = 3'b011;
  localparam logic [2:0] F3Xor  = 3'b100;
  localparam logic [2:0] F3Srl  = 3'b101;
  localparam logic [2:0] F3Or   = 3'b110;
  localparam logic [2:0] F3And  = 3'b111;

  // branch and jump funct3
  localparam logic [2:0] F3Jalr = 3'b000;
  localparam logic [2:0] F3Beq  = 3'b000;
  localparam logic [2:0] F3Bne  = 3'b001;
  localparam logic [2:0] F3Blt  = 3'b100;
  localparam logic [2:0] F3Bge  = 3'b101;
  localparam logic [2:0] F3Bltu = 3'b110;
  localparam logic [2:0] F3Bgeu = 3'b111;

  // funct7, and its upper six bits for 64-bit shift immediates
  localparam logic [6:0] F7Base = 7'b0000000;
  localparam logic [6:0] F7Alt  = 7'b0100000;
  localparam logic [5:0] F6Base = 6'b000000;
  localparam logic [5:0] F6Alt  = 6'b010000;

  typedef enum logic [3:0] {
    AluAdd, AluSub, AluSll, AluSlt, AluSltu, AluXor, AluSrl, AluSra, AluOr, AluAnd
  } aluOpE;

  typedef enum logic [2:0] {
    ClsLui, ClsAuipc, ClsJal, ClsJalr, ClsBranch, ClsAlu, ClsNop
  } opClassE;

  typedef struct packed {
    opClassE    opClass;
    aluOpE      aluOp;
    logic [2:0] funct3;
    logic       useImm;
    logic       word32;
    logic       rdWrite;
    regIdx      rs1;
    regIdx      rs2;
    regIdx      rd;
    xword       imm;
  } decodedOp;

  typedef struct packed {
    xword  pc;
    xword  nextPc;
    regIdx rd;
    logic  rdWrite;
    xword  rdValue;
  } retireRec;

endpackage

`default_nettype wire

// ==== rvCore.f ====
design/rvCorePkg.sv
design/regFile.sv
design/instDecoder.sv
design/intExecute.sv
design/retireStage.sv
design/rvCore.sv
test/retireStage_chk.sv
test/retireMonitor.sv
test/rvCoreTb.sv

// ==== test/retireMonitor.sv ====
`timescale 1ns/10ps
`default_nettype none

module retireMonitor (
  input  logic                clk,
  input  logic                rst,
  input  logic                instValid,
  input  rvCorePkg::instWord  instIn,
  input  logic                retireValid,
  input  rvCorePkg::retireRec retireOut,
  output int                  mismatches,
  output int                  otherErrors,
  output int                  retired
);
  import rvCorePkg::*;

  instWord pending [$];
  xword    modelRegs [32];
  xword    modelPc;

  function automatic xword alu64(input logic [2:0] f3, input logic alt, input xword a,
                                 input xword b);
    logic signed [63:0] sa;
    xword               res;
    sa = a;
    case (f3)
      3'b000:  res = alt ? a - b : a + b;
      3'b001:  res = a << b[5:0];
      3'b010:  res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      3'b011:  res = (a < b) ? 64'd1 : 64'd0;
      3'b100:  res = a ^ b;
      3'b110:  res = a | b;
      3'b111:  res = a & b;
      default: begin
        if (alt) begin
          res = sa >>> b[5:0];
        end else begin
          res = a >> b[5:0];
        end
      end
    endcase
    return res;
  endfunction

  // W forms work on the low word and sign-extend bit 31
  function automatic xword aluWord(input logic [2:0] f3, input logic alt, input xword a,
                                   input xword b);
    logic signed [31:0] sa;
    logic [31:0]        lo;
    sa = a[31:0];
    if (f3 == 3'b000) begin
      lo = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
    end else if (f3 == 3'b001) begin
      lo = a[31:0] << b[4:0];
    end else if (alt) begin
      lo = sa >>> b[4:0];
    end else begin
      lo = a[31:0] >> b[4:0];
    end
    return {{32{lo[31]}}, lo};
  endfunction

  function automatic retireRec refRetire(input instWord w, input xword pc, input xword a,
                                         input xword b);
    retireRec   e;
    logic [2:0] f3;
    logic [6:0] f7;
    xword       immI;
    xword       immB;
    xword       immU;
    xword       immJ;
    logic       taken;
    f3   = w[14:12];
    f7   = w[31:25];
    immI = {{52{w[31]}}, w[31:20]};
    immB = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    immU = {{32{w[31]}}, w[31:12], 12'h000};
    immJ = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    e.pc      = pc;
    e.nextPc  = pc + 64'd4;
    e.rd      = w[11:7];
    e.rdWrite = 1'b0;
    e.rdValue = '0;
    taken     = 1'b0;
    case (w[6:0])
      OpLui: begin
        e.rdWrite = 1'b1;
        e.rdValue = immU;
      end
      OpAuipc: begin
        e.rdWrite = 1'b1;
        e.rdValue = pc + immU;
      end
      OpJal: begin
        e.rdWrite = 1'b1;
        e.rdValue = pc + 64'd4;
        e.nextPc  = pc + immJ;
      end
      OpJalr: begin
        if (f3 == 3'b000) begin
          e.rdWrite = 1'b1;
          e.rdValue = pc + 64'd4;
          e.nextPc  = (a + immI) & ~64'd1;
        end
      end
      OpBranch: begin
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = $signed(a) < $signed(b);
          3'b101:  taken = $signed(a) >= $signed(b);
          3'b110:  taken = a < b;
          3'b111:  taken = a >= b;
          default: taken = 1'b0;
        endcase
        if (taken) begin
          e.nextPc = pc + immB;
        end
      end
      OpImm: begin
        if ((f3 != 3'b001 || w[31:26] == 6'b000000) &&
            (f3 != 3'b101 || w[31:26] == 6'b000000 || w[31:26] == 6'b010000)) begin
          e.rdWrite = 1'b1;
          e.rdValue = alu64(f3, f3 == 3'b101 && w[30], a, immI);
        end
      end
      OpReg: begin
        if (f7 == 7'b0000000 || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101))) begin
          e.rdWrite = 1'b1;
          e.rdValue = alu64(f3, w[30], a, b);
        end
      end
      OpImm32: begin
        if (f3 == 3'b000 || (f3 == 3'b001 && f7 == 7'b0000000) ||
            (f3 == 3'b101 && (f7 == 7'b0000000 || f7 == 7'b0100000))) begin
          e.rdWrite = 1'b1;
          e.rdValue = aluWord(f3, f3 == 3'b101 && w[30], a, immI);
        end
      end
      OpReg32: begin
        if ((f3 == 3'b000 || f3 == 3'b101) && (f7 == 7'b0000000 || f7 == 7'b0100000) ||
            (f3 == 3'b001 && f7 == 7'b0000000)) begin
          e.rdWrite = 1'b1;
          e.rdValue = aluWord(f3, w[30], a, b);
        end
      end
      default: ;
    endcase
    return e;
  endfunction

  task automatic compareField(input string name, input xword got, input xword exp,
                              inout int errs);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      errs++;
    end
  endtask

  always @(posedge clk) begin
    int       errs;
    instWord  w;
    retireRec exp;
    errs = 0;
    if (rst) begin
      pending.delete();
      modelPc = ResetPc;
      for (int i = 0; i < 32; i++) begin
        modelRegs[i] = '0;
      end
      mismatches  <= 0;
      otherErrors <= 0;
      retired     <= 0;
    end else begin
      if (instValid) begin
        pending.push_back(instIn);
      end
      if (retireValid) begin
        if (pending.size() == 0) begin
          $display("at %0t a record retired with no instruction left to match it", $time);
          otherErrors <= otherErrors + 1;
        end else begin
          w   = pending.pop_front();
          exp = refRetire(w, modelPc, modelRegs[w[19:15]], modelRegs[w[24:20]]);
          compareField("pc", retireOut.pc, exp.pc, errs);
          compareField("nextPc", retireOut.nextPc, exp.nextPc, errs);
          compareField("rdWrite", xword'(retireOut.rdWrite), xword'(exp.rdWrite), errs);
          // rd and rdValue only carry meaning for a register write
          if (exp.rdWrite) begin
            compareField("rd", xword'(retireOut.rd), xword'(exp.rd), errs);
            compareField("rdValue", retireOut.rdValue, exp.rdValue, errs);
          end
          modelPc = exp.nextPc;
          if (exp.rdWrite && exp.rd != '0) begin
            modelRegs[exp.rd] = exp.rdValue;
          end
          mismatches <= mismatches + errs;
        end
        retired <= retired + 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/retireStage_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module retireStage_chk (
  input logic                             clk,
  input logic                             rst,
  input logic                             retireValid,
  input logic                             retireCredit,
  input logic                             wrEn,
  input logic [rvCorePkg::CreditBits-1:0] creditCnt
);
  import rvCorePkg::*;

  // output credits granted and not yet spent
  int heldCredits;

  always_ff @(posedge clk) begin
    if (rst) begin
      heldCredits <= 0;
    end else begin
      heldCredits <= heldCredits + int'(retireCredit) - int'(retireValid);
    end
  end

  // a record leaves only against a granted credit
  spendNeedsCredit: assert property (
    @(posedge clk) disable iff (rst) retireValid |-> (heldCredits > 0)
  ) else $error("retireValid asserted with no output credit granted");

  // counter follows grants minus spends and stays in range
  counterTracksGrants: assert property (
    @(posedge clk) disable iff (rst)
      (heldCredits < (1 << CreditBits)) && (creditCnt == CreditBits'(heldCredits))
  ) else $error("output credit counter out of range or out of step with the grants");

  // outputs stay low through reset
  quietInReset: assert property (
    @(posedge clk) rst |=> (!retireValid && !wrEn)
  ) else $error("retireValid or wrEn active during reset");

endmodule

`default_nettype wire

// ==== test/rvCoreTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvCoreTb;
  import rvCorePkg::*;

  localparam int          NumInst       = 400;
  localparam int          SendTimeout   = 40000;
  localparam int          RetireTimeout = 40000;
  localparam int          DrainCycles   = 40;
  localparam int          MaxGrant      = 6;
  localparam logic [31:0] Seed          = 32'h84a4_b79c;

  logic        clk;
  logic        rst;
  logic        instValid;
  instWord     instIn;
  logic        instCredit;
  logic        retireValid;
  retireRec    retireOut;
  logic        retireCredit;
  int          mismatches;
  int          otherErrors;
  int          retired;
  int          tbErrors;
  logic [31:0] rngState;
  int          upCredits;
  int          sent;
  int          grantsOut;
  int          pauseLeft;

  rvCore u_dut (
    .clk          (clk),
    .rst          (rst),
    .instValid    (instValid),
    .instIn       (instIn),
    .instCredit   (instCredit),
    .retireValid  (retireValid),
    .retireOut    (retireOut),
    .retireCredit (retireCredit)
  );

  retireMonitor uMonitor (
    .clk         (clk),
    .rst         (rst),
    .instValid   (instValid),
    .instIn      (instIn),
    .retireValid (retireValid),
    .retireOut   (retireOut),
    .mismatches  (mismatches),
    .otherErrors (otherErrors),
    .retired     (retired)
  );

  bind retireStage retireStage_chk uRetireChk (
    .clk          (clk),
    .rst          (rst),
    .retireValid  (retireValid),
    .retireCredit (retireCredit),
    .wrEn         (wrEn),
    .creditCnt    (creditCnt)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // registers limited to x0..x7 so dependences show up often
  function automatic instWord makeInst();
    logic [31:0] r;
    logic [31:0] v;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    instWord     w;
    r   = nextRand();
    v   = nextRand();
    rd  = {2'b00, r[2:0]};
    rs1 = {2'b00, r[5:3]};
    rs2 = {2'b00, r[8:6]};
    f3  = r[11:9];
    f7  = (r[16] && (f3 == F3Add || f3 == F3Srl)) ? F7Alt : F7Base;
    imm = v[11:0];
    case (r[15:12])
      4'd0, 4'd1, 4'd2: begin
        if (f3 == F3Sll || f3 == F3Srl) begin
          imm = {f7[6:1], v[5:0]};
        end
        w = {imm, rs1, f3, rd, OpImm};
      end
      4'd3, 4'd4: w = {f7, rs2, rs1, f3, rd, OpReg};
      4'd5, 4'd6: begin
        f3 = (r[10:9] == 2'd1) ? F3Sll : (r[10:9] == 2'd2) ? F3Srl : F3Add;
        f7 = (r[16] && f3 != F3Sll) ? F7Alt : F7Base;
        if (r[12]) begin
          w = {f7, rs2, rs1, f3, rd, OpReg32};
        end else begin
          if (f3 != F3Add) begin
            imm = {(f3 == F3Srl) ? f7 : F7Base, v[4:0]};
          end
          w = {imm, rs1, f3, rd, OpImm32};
        end
      end
      4'd7: w = {v[31:12], rd, OpLui};
      4'd8: w = {v[31:12], rd, OpAuipc};
      4'd9: w = {v[31:12], rd, OpJal};
      4'd10: w = {imm, rs1, F3Jalr, rd, OpJalr};
      4'd11, 4'd12: begin
        if (f3[2:1] == 2'b01) begin
          f3 = {1'b1, f3[1:0]};
        end
        w = {v[31:25], rs2, rs1, f3, v[11:7], OpBranch};
      end
      4'd13: begin
        // encodings outside the supported set
        case (r[17:16])
          2'd0:    w = {imm, rs1, 3'b011, rd, 7'b0000011};
          2'd1:    w = {7'b0000001, rs2, rs1, f3, rd, OpReg};
          2'd2:    w = {v[31:25], rs2, rs1, 3'b010, v[11:7], OpBranch};
          default: w = {F7Alt, rs2, rs1, F3Sll, rd, OpReg32};
        endcase
      end
      default: w = {imm, rs1, f3, rd, OpImm};
    endcase
    // first seven words give x1..x7 a known value
    if (sent < 7) begin
      w = {imm, 5'd0, F3Add, 5'(sent + 1), OpImm};
    end
    return w;
  endfunction

  // one clock of upstream sending and downstream credit grants
  task automatic driveCycle();
    @(posedge clk);
    if (instCredit) begin
      upCredits++;
    end
    if (upCredits > InQueueDepth) begin
      $display("at %0t the core returned more input credits than were spent", $time);
      tbErrors++;
    end
    if (retireValid) begin
      grantsOut--;
    end
    if (grantsOut < 0) begin
      $display("at %0t a record retired without an output credit granted", $time);
      tbErrors++;
    end
    if (sent < NumInst && upCredits > 0 && nextRand() % 4 != 0) begin
      instValid <= 1'b1;
      instIn    <= makeInst();
      upCredits--;
      sent++;
    end else begin
      instValid <= 1'b0;
    end
    if (pauseLeft > 0) begin
      pauseLeft--;
      retireCredit <= 1'b0;
    end else if (nextRand() % 24 == 0) begin
      pauseLeft = 20 + int'(nextRand() % 60);
      retireCredit <= 1'b0;
    end else if (grantsOut < MaxGrant && nextRand() % 2 == 0) begin
      retireCredit <= 1'b1;
      grantsOut++;
    end else begin
      retireCredit <= 1'b0;
    end
  endtask

  initial begin
    int cycles;
    clk          = 1'b0;
    rst          = 1'b1;
    instValid    = 1'b0;
    instIn       = '0;
    retireCredit = 1'b0;
    rngState     = Seed;
    upCredits    = InQueueDepth;
    sent         = 0;
    grantsOut    = 0;
    pauseLeft    = 0;
    tbErrors     = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    cycles = 0;
    while (sent < NumInst && cycles < SendTimeout) begin
      driveCycle();
      cycles++;
    end
    if (sent < NumInst) begin
      $display("timed out with only %0d of %0d instructions sent", sent, NumInst);
      tbErrors++;
    end else begin
      cycles = 0;
      while (retired < NumInst && cycles < RetireTimeout) begin
        driveCycle();
        cycles++;
      end
      if (retired < NumInst) begin
        $display("timed out with only %0d of %0d instructions retired", retired, NumInst);
        tbErrors++;
      end else begin
        // extra retires after the last one would show up here
        repeat (DrainCycles) driveCycle();
      end
    end
    $display("errors: %0d mismatches, %0d retire errors, %0d protocol errors",
             mismatches, otherErrors, tbErrors);
    if (mismatches == 0 && otherErrors == 0 && tbErrors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
